/* verilog.f */
hw/mips_pkg.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_muldiv.sv
hw/mips_pc_control.sv
hw/mips_cpu_harvard.sv
verif/mips_harvard_mem.sv
verif/mips_cpu_tb.sv

/* verif/mips_stim.txt */
# prog <addr> <word> | data <addr> <word> | expmem <addr> <word>   (hex)
# expv0 <hex> | expcyc <dec> | randen <0/1> | rstmid <dec> | run
# test 1: alu, shifts, slt/sltu, lui
prog bfc00000 3c081234
prog bfc00004 35085678
prog bfc00008 2409ffff
prog bfc0000c 0120502a
prog bfc00010 0009682b
prog bfc00014 00085902
prog bfc00018 00082200
prog bfc0001c 00093903
prog bfc00020 010b1026
prog bfc00024 004a1021
prog bfc00028 00803027
prog bfc0002c 00461023
prog bfc00030 3842ffff
prog bfc00034 28e30005
prog bfc00038 00431021
prog bfc0003c 004d1021
prog bfc00040 00000008
prog bfc00044 00000000
expv0 476d74e0
expcyc 36
run
# test 2: sw/lw round trip
prog bfc00000 8c080104
prog bfc00004 25080001
prog bfc00008 ac080104
prog bfc0000c 8c020104
prog bfc00010 3c09dead
prog bfc00014 ac09010c
prog bfc00018 8c0a010c
prog bfc0001c 004a1021
prog bfc00020 00000008
prog bfc00024 00000000
data 00000100 11111111
data 00000104 22222222
data 00000108 33333333
expv0 00cf2223
expmem 00000100 11111111
expmem 00000104 22222223
expmem 00000108 33333333
expmem 0000010c dead0000
expmem 00000110 00000000
expcyc 20
run
# test 3: same program with a random clk_enable
data 00000100 11111111
data 00000104 22222222
data 00000108 33333333
expv0 00cf2223
expmem 00000100 11111111
expmem 00000104 22222223
expmem 00000108 33333333
expmem 0000010c dead0000
expmem 00000110 00000000
expcyc 20
randen 1
run
# test 4: branches, jumps and links, with a reset mid-program
prog bfc00000 24080005
prog bfc00004 11000003
prog bfc00008 24020001
prog bfc0000c 15000004
prog bfc00010 24420002
prog bfc00014 24420100
prog bfc00020 2409ffff
prog bfc00024 05300006
prog bfc00028 24420004
prog bfc0002c 24420200
prog bfc00040 03e08021
prog bfc00044 0bf00018
prog bfc00048 24420008
prog bfc0004c 24420400
prog bfc00060 0ff00020
prog bfc00064 24420010
prog bfc00080 03f08823
prog bfc00084 00511021
prog bfc00088 3c0bbfc0
prog bfc0008c 356b00a0
prog bfc00090 0160a009
prog bfc00094 24420020
prog bfc00098 24420800
prog bfc000a0 02909023
prog bfc000a4 00521021
prog bfc000a8 00000008
prog bfc000ac 24420040
expv0 00000127
expcyc 46
rstmid 15
run
# test 5: mult, multu, mfhi, mflo, mthi, mtlo
prog bfc00000 2408fffd
prog bfc00004 24090007
prog bfc00008 01090018
prog bfc0000c 00005010
prog bfc00010 00005812
prog bfc00014 01090019
prog bfc00018 00006010
prog bfc0001c 014b1026
prog bfc00020 004c1021
prog bfc00024 00400011
prog bfc00028 01200013
prog bfc0002c 00006810
prog bfc00030 00007012
prog bfc00034 000d1200
prog bfc00038 004e1021
prog bfc0003c 00000008
prog bfc00040 00000000
expv0 00001a07
expcyc 34
run

/* verif/mips_cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    // parsed stimulus, one entry per keyword line
    string       cmd_kind [$];
    logic [31:0] cmd_a [$];
    logic [31:0] cmd_b [$];

    integer      seed = 70458;
    int          watchdog_cycles;
    logic        watchdog_armed = 1'b0;

    // expectations of the current test
    int          test_num = 0;
    logic [31:0] exp_v0;
    bit          has_v0;
    int          exp_cycles;
    int          rst_mid;
    bit          rand_en;
    bit          rom_loaded;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_word [$];

    mips_cpu_harvard #(.XLEN(32)) mips_cpu_harvard_inst (
        .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
        .register_v0(register_v0), .instr_address(instr_address),
        .instr_readdata(instr_readdata), .data_address(data_address),
        .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata), .data_readdata(data_readdata)
    );

    mips_harvard_mem mem_inst (
        .clk(clk), .instr_address(instr_address), .instr_readdata(instr_readdata),
        .data_address(data_address), .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata), .data_readdata(data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic stop_run(input string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    task automatic read_stim();
        int          fd;
        int          code;
        string       kw;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verif/mips_stim.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open verif/mips_stim.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kw);
            if (code == 1) begin
                a = '0;
                b = '0;
                if (kw[0] == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    if (kw == "prog" || kw == "data" || kw == "expmem") begin
                        code = $fscanf(fd, "%h %h", a, b);
                    end else if (kw == "expv0") begin
                        code = $fscanf(fd, "%h", a);
                    end else if (kw != "run") begin
                        code = $fscanf(fd, "%d", a);
                    end
                    cmd_kind.push_back(kw);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic start_test();
        test_num++;
        has_v0     = 1'b0;
        exp_cycles = 0;
        rst_mid    = 0;
        rand_en    = 1'b0;
        rom_loaded = 1'b0;
        exp_addr.delete();
        exp_word.delete();
        for (int i = 0; i < 256; i++) begin
            mem_inst.ram[i] = 32'h0000_0000;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset      <= 1'b1;
        clk_enable <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    // counts enabled edges until active falls
    task automatic run_program(output int en_edges);
        bit mid_done;
        en_edges = 0;
        mid_done = 1'b0;
        while (active) begin
            @(posedge clk);
            if (clk_enable) begin
                en_edges++;
            end
            if (rand_en) begin
                clk_enable <= (($random(seed) & 3) != 0);
            end
            @(negedge clk);
            if (rst_mid > 0 && !mid_done && en_edges == rst_mid) begin
                mid_done = 1'b1;
                @(posedge clk);
                reset      <= 1'b1;
                clk_enable <= 1'b1;
                @(posedge clk);
                @(negedge clk);
                check_value("active after mid-program reset", {31'b0, active}, 32'd1);
                check_value("instr_address after mid-program reset", instr_address,
                            BOOT_ADDR);
                repeat (RESET_CYCLES - 1) @(posedge clk);
                reset <= 1'b0;
                @(negedge clk);
                en_edges = 0;
            end
        end
    endtask

    task automatic run_test();
        int en_edges;
        apply_reset();
        check_value("active after reset", {31'b0, active}, 32'd1);
        check_value("instr_address after reset", instr_address, BOOT_ADDR);
        run_program(en_edges);
        if (has_v0) begin
            check_value($sformatf("test %0d register_v0", test_num), register_v0, exp_v0);
        end
        if (exp_cycles > 0) begin
            check_value($sformatf("test %0d cycles to halt", test_num), en_edges, exp_cycles);
        end
        foreach (exp_addr[i]) begin
            check_value($sformatf("test %0d data word %h", test_num, exp_addr[i]),
                        mem_inst.ram[exp_addr[i][9:2]], exp_word[i]);
        end
        $display("test %0d halted after %0d enabled cycles", test_num, en_edges);
    endtask

    // watchdog, budget set once the stim file is parsed
    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERRORS FOUND");
        $fatal(1, "timeout, the processor never halted within %0d cycles", watchdog_cycles);
    end

    initial begin
        int          words;
        int          runs;
        logic [31:0] offset;
        reset      = 1'b1;
        clk_enable = 1'b1;
        words      = 0;
        runs       = 0;
        read_stim();
        foreach (cmd_kind[i]) begin
            if (cmd_kind[i] == "prog") words++;
            if (cmd_kind[i] == "run" || cmd_kind[i] == "rstmid") runs++;
        end
        watchdog_cycles = 2 * words * 64 + (RESET_CYCLES + 4) * runs;
        watchdog_armed  = 1'b1;
        start_test();
        foreach (cmd_kind[i]) begin
            if (cmd_kind[i] == "prog") begin
                offset = cmd_a[i] - BOOT_ADDR;
                if (offset >= 32'd256) begin
                    stop_run($sformatf("program address %h lies outside the ROM", cmd_a[i]));
                end
                if (!rom_loaded) begin
                    for (int j = 0; j < 64; j++) begin
                        mem_inst.rom[j] = 32'h0000_0000;
                    end
                    rom_loaded = 1'b1;
                end
                mem_inst.rom[offset[7:2]] = cmd_b[i];
            end else if (cmd_kind[i] == "data") begin
                mem_inst.ram[cmd_a[i][9:2]] = cmd_b[i];
            end else if (cmd_kind[i] == "expv0") begin
                exp_v0 = cmd_a[i];
                has_v0 = 1'b1;
            end else if (cmd_kind[i] == "expmem") begin
                exp_addr.push_back(cmd_a[i]);
                exp_word.push_back(cmd_b[i]);
            end else if (cmd_kind[i] == "expcyc") begin
                exp_cycles = cmd_a[i];
            end else if (cmd_kind[i] == "randen") begin
                rand_en = cmd_a[i][0];
            end else if (cmd_kind[i] == "rstmid") begin
                rst_mid = cmd_a[i];
            end else if (cmd_kind[i] == "run") begin
                run_test();
                start_test();
            end else begin
                stop_run($sformatf("unknown keyword %s in the stim file", cmd_kind[i]));
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mips_harvard_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_harvard_mem (
    input  logic        clk,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic        data_read,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);
    import mips_pkg::*;

    // 64-word ROM at the boot address, 256-word RAM aliased over the data space
    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic [31:0] rom_offset;

    assign rom_offset = instr_address - BOOT_ADDR;

    // anything outside the ROM fetches a nop
    always_comb begin
        if (rom_offset < 32'd256) begin
            instr_readdata = rom[rom_offset[7:2]];
        end else begin
            instr_readdata = 32'h0000_0000;
        end
    end

    assign data_readdata = data_read ? ram[data_address[9:2]] : 32'h0000_0000;

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[9:2]] <= data_writedata;
        end
    end

endmodule

`default_nettype wire

/* hw/mips_cpu_harvard.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard #(
    // only a 32-bit data width is supported by this MIPS-I subset
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    output logic            active,
    output logic [XLEN-1:0] register_v0,
    output logic [31:0]     instr_address,
    input  logic [31:0]     instr_readdata,
    output logic [31:0]     data_address,
    output logic            data_write,
    output logic            data_read,
    output logic [XLEN-1:0] data_writedata,
    input  logic [XLEN-1:0] data_readdata
);
    import mips_pkg::*;

    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      rd_index;
    alu_op_t         alu_op;
    branch_t         branch_cond;
    logic            use_imm;
    logic            imm_zero_ext;
    logic            reg_write;
    logic            mem_to_reg;
    logic            link;
    logic            j_imm;
    logic            j_reg;
    logic            mul_start;
    logic            mul_signed;
    logic            hi_write;
    logic            lo_write;
    logic            sel_hi;
    logic            sel_lo;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] eff_addr;
    logic            take_branch;
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
    logic [31:0]     pc;
    logic [31:0]     delay_slot;
    logic            commit;

    mips_decoder decoder_inst (
        .instr(instr_readdata), .rs(rs), .rt(rt), .rd_index(rd_index),
        .alu_op(alu_op), .use_imm(use_imm), .imm_zero_ext(imm_zero_ext),
        .branch_cond(branch_cond), .reg_write(reg_write), .mem_to_reg(mem_to_reg),
        .link(link), .j_imm(j_imm), .j_reg(j_reg), .mul_start(mul_start),
        .mul_signed(mul_signed), .hi_write(hi_write), .lo_write(lo_write),
        .sel_hi(sel_hi), .sel_lo(sel_lo), .is_load(is_load), .is_store(is_store)
    );

    // write-back priority is link, hi, lo, load, then alu
    always_comb begin
        if (link) begin
            wb_data = delay_slot + 32'd4;
        end else if (sel_hi) begin
            wb_data = hi;
        end else if (sel_lo) begin
            wb_data = lo;
        end else if (mem_to_reg) begin
            wb_data = data_readdata;
        end else begin
            wb_data = result;
        end
    end

    mips_regfile #(.XLEN(XLEN)) regfile_inst (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .rs(rs), .rt(rt), .wr_index(rd_index), .wr_data(wb_data),
        .wr_en(reg_write && commit),
        .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
    );

    mips_alu #(.XLEN(XLEN)) alu_inst (
        .alu_op(alu_op), .branch_cond(branch_cond), .a(rs_data), .b(rt_data),
        .imm(instr_readdata[15:0]), .shamt(instr_readdata[10:6]),
        .use_imm(use_imm), .imm_zero_ext(imm_zero_ext),
        .result(result), .eff_addr(eff_addr), .take_branch(take_branch)
    );

    mips_muldiv #(.XLEN(XLEN)) muldiv_inst (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .start(mul_start && commit), .signed_mode(mul_signed),
        .a(rs_data), .b(rt_data),
        .hi_write(hi_write && commit), .lo_write(lo_write && commit),
        .hi(hi), .lo(lo)
    );

    mips_pc_control pc_control_inst (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .take_branch(take_branch), .j_imm(j_imm), .j_reg(j_reg),
        .jump_field(instr_readdata[25:0]), .branch_offset(instr_readdata[15:0]),
        .rs_data(rs_data), .pc(pc), .delay_slot(delay_slot),
        .state(), .commit(commit), .active(active)
    );

    assign instr_address  = pc;
    // word-aligned data port
    assign data_address   = {eff_addr[31:2], 2'b00};
    assign data_writedata = rt_data;
    assign data_write     = is_store && commit;
    assign data_read      = is_load && active;

endmodule

`default_nettype wire

/* hw/mips_pc_control.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_pc_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_enable,
    input  logic                 take_branch,
    input  logic                 j_imm,
    input  logic                 j_reg,
    input  logic [25:0]          jump_field,
    input  logic [15:0]          branch_offset,
    input  logic [31:0]          rs_data,
    output logic [31:0]          pc,
    output logic [31:0]          delay_slot,
    output mips_pkg::cpu_state_t state,
    output logic                 commit,
    output logic                 active
);
    import mips_pkg::*;

    logic [31:0] next_addr;

    // target of the instruction after the delay slot
    always_comb begin
        if (take_branch) begin
            next_addr = delay_slot + {{14{branch_offset[15]}}, branch_offset, 2'b00};
        end else if (j_imm) begin
            next_addr = {delay_slot[31:28], jump_field, 2'b00};
        end else if (j_reg) begin
            next_addr = rs_data;
        end else begin
            next_addr = delay_slot + 32'd4;
        end
    end

    assign commit = active && (state == st_commit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_execute;
            pc         <= BOOT_ADDR;
            delay_slot <= BOOT_ADDR + 32'd4;
            active     <= 1'b1;
        end else if (clk_enable && active) begin
            if (state == st_execute) begin
                state <= st_commit;
            end else begin
                state      <= st_execute;
                pc         <= delay_slot;
                delay_slot <= next_addr;
                // halt once the fetch would go to address zero
                if (delay_slot == 32'd0) begin
                    active <= 1'b0;
                end
            end
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        active |-> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

/* hw/mips_muldiv.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_muldiv #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    input  logic            start,
    input  logic            signed_mode,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic            hi_write,
    input  logic            lo_write,
    output logic [XLEN-1:0] hi,
    output logic [XLEN-1:0] lo
);

    logic [2*XLEN-1:0] product;

    // full-width product with sign-extended operands for mult
    always_comb begin
        if (signed_mode) begin
            product = $signed(a) * $signed(b);
        end else begin
            product = a * b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (clk_enable) begin
            if (start) begin
                {hi, lo} <= product;
            end else begin
                // mthi / mtlo move rs
                if (hi_write) begin
                    hi <= a;
                end
                if (lo_write) begin
                    lo <= a;
                end
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        start |-> !(hi_write || lo_write));

endmodule

`default_nettype wire

/* hw/mips_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_alu #(
    parameter int XLEN = 32
) (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::branch_t branch_cond,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    input  logic [15:0]       imm,
    input  logic [4:0]        shamt,
    input  logic              use_imm,
    input  logic              imm_zero_ext,
    output logic [XLEN-1:0]   result,
    output logic [XLEN-1:0]   eff_addr,
    output logic              take_branch
);
    import mips_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] op_b;

    assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
    assign imm_ext  = imm_zero_ext ? {{(XLEN-16){1'b0}}, imm} : imm_sext;
    assign op_b     = use_imm ? imm_ext : b;

    // load/store address, always signed offset
    assign eff_addr = a + imm_sext;

    always_comb begin
        case (alu_op)
            alu_add:  result = a + op_b;
            alu_sub:  result = a - op_b;
            alu_and:  result = a & op_b;
            alu_or:   result = a | op_b;
            alu_xor:  result = a ^ op_b;
            alu_nor:  result = ~(a | op_b);
            alu_slt:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(op_b)};
            alu_sltu: result = {{(XLEN-1){1'b0}}, a < op_b};
            // shifts take rt and the shamt field
            alu_sll:  result = op_b << shamt;
            alu_srl:  result = op_b >> shamt;
            alu_sra:  result = $unsigned($signed(op_b) >>> shamt);
            alu_lui:  result = {imm, {(XLEN-16){1'b0}}};
            default:  result = op_b;
        endcase
    end

    always_comb begin
        case (branch_cond)
            br_eq:   take_branch = (a == b);
            br_ne:   take_branch = (a != b);
            br_ltz:  take_branch = a[XLEN-1];
            br_gez:  take_branch = !a[XLEN-1];
            default: take_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/mips_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_regfile #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    input  logic [4:0]      rs,
    input  logic [4:0]      rt,
    input  logic [4:0]      wr_index,
    input  logic [XLEN-1:0] wr_data,
    input  logic            wr_en,
    output logic [XLEN-1:0] rs_data,
    output logic [XLEN-1:0] rt_data,
    output logic [XLEN-1:0] register_v0
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && wr_en && wr_index != 5'd0) begin
            // $zero is never written so it keeps its reset value
            regs[wr_index] <= wr_data;
        end
    end

    assign rs_data     = regs[rs];
    assign rt_data     = regs[rt];
    assign register_v0 = regs[2];

    a_v0_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(register_v0));

endmodule

`default_nettype wire

/* hw/mips_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_decoder (
    input  logic [31:0]        instr,
    output logic [4:0]         rs,
    output logic [4:0]         rt,
    output logic [4:0]         rd_index,
    output mips_pkg::alu_op_t  alu_op,
    output logic               use_imm,
    output logic               imm_zero_ext,
    output mips_pkg::branch_t  branch_cond,
    output logic               reg_write,
    output logic               mem_to_reg,
    output logic               link,
    output logic               j_imm,
    output logic               j_reg,
    output logic               mul_start,
    output logic               mul_signed,
    output logic               hi_write,
    output logic               lo_write,
    output logic               sel_hi,
    output logic               sel_lo,
    output logic               is_load,
    output logic               is_store
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    regimm_t regimm;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign regimm = regimm_t'(instr[20:16]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    always_comb begin
        alu_op       = alu_pass_b;
        branch_cond  = br_none;
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        mem_to_reg   = 1'b0;
        link         = 1'b0;
        j_imm        = 1'b0;
        j_reg        = 1'b0;
        mul_start    = 1'b0;
        mul_signed   = 1'b0;
        hi_write     = 1'b0;
        lo_write     = 1'b0;
        sel_hi       = 1'b0;
        sel_lo       = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;

        case (opcode)
            op_special: begin
                // most R-type ops write rd, the rest clear it below
                reg_write = 1'b1;
                case (funct)
                    fn_addu:  alu_op = alu_add;
                    fn_subu:  alu_op = alu_sub;
                    fn_and:   alu_op = alu_and;
                    fn_or:    alu_op = alu_or;
                    fn_xor:   alu_op = alu_xor;
                    fn_nor:   alu_op = alu_nor;
                    fn_slt:   alu_op = alu_slt;
                    fn_sltu:  alu_op = alu_sltu;
                    fn_sll:   alu_op = alu_sll;
                    fn_srl:   alu_op = alu_srl;
                    fn_sra:   alu_op = alu_sra;
                    fn_mfhi:  sel_hi = 1'b1;
                    fn_mflo:  sel_lo = 1'b1;
                    fn_jalr: begin
                        j_reg = 1'b1;
                        link  = 1'b1;
                    end
                    fn_jr: begin
                        j_reg     = 1'b1;
                        reg_write = 1'b0;
                    end
                    fn_mult: begin
                        mul_start  = 1'b1;
                        mul_signed = 1'b1;
                        reg_write  = 1'b0;
                    end
                    fn_multu: begin
                        mul_start = 1'b1;
                        reg_write = 1'b0;
                    end
                    fn_mthi: begin
                        hi_write  = 1'b1;
                        reg_write = 1'b0;
                    end
                    fn_mtlo: begin
                        lo_write  = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            op_regimm: begin
                case (regimm)
                    ri_bltz: branch_cond = br_ltz;
                    ri_bgez: branch_cond = br_gez;
                    ri_bltzal: begin
                        branch_cond = br_ltz;
                        link        = 1'b1;
                        reg_write   = 1'b1;
                    end
                    ri_bgezal: begin
                        branch_cond = br_gez;
                        link        = 1'b1;
                        reg_write   = 1'b1;
                    end
                    default: branch_cond = br_none;
                endcase
            end
            op_j:   j_imm = 1'b1;
            op_jal: begin
                j_imm     = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            op_beq: branch_cond = br_eq;
            op_bne: branch_cond = br_ne;
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                use_imm      = 1'b1;
                reg_write    = 1'b1;
                imm_zero_ext = (opcode == op_andi) || (opcode == op_ori) ||
                               (opcode == op_xori);
                case (opcode)
                    op_addiu: alu_op = alu_add;
                    op_slti:  alu_op = alu_slt;
                    op_sltiu: alu_op = alu_sltu;
                    op_andi:  alu_op = alu_and;
                    op_ori:   alu_op = alu_or;
                    op_xori:  alu_op = alu_xor;
                    default:  alu_op = alu_lui;
                endcase
            end
            op_lw: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                is_load    = 1'b1;
            end
            op_sw:   is_store = 1'b1;
            default: reg_write = 1'b0;
        endcase
    end

    // jal and the linking branches always target $ra
    always_comb begin
        if (opcode == op_jal || (opcode == op_regimm && link)) begin
            rd_index = 5'd31;
        end else if (opcode == op_special) begin
            rd_index = instr[15:11];
        end else begin
            rd_index = instr[20:16];
        end
    end

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'd0,
        op_regimm  = 6'd1,
        op_j       = 6'd2,
        op_jal     = 6'd3,
        op_beq     = 6'd4,
        op_bne     = 6'd5,
        op_addiu   = 6'd9,
        op_slti    = 6'd10,
        op_sltiu   = 6'd11,
        op_andi    = 6'd12,
        op_ori     = 6'd13,
        op_xori    = 6'd14,
        op_lui     = 6'd15,
        op_lw      = 6'd35,
        op_sw      = 6'd43
    } opcode_t;

    // function field of special opcode
    typedef enum logic [5:0] {
        fn_sll   = 6'd0,
        fn_srl   = 6'd2,
        fn_sra   = 6'd3,
        fn_jr    = 6'd8,
        fn_jalr  = 6'd9,
        fn_mfhi  = 6'd16,
        fn_mthi  = 6'd17,
        fn_mflo  = 6'd18,
        fn_mtlo  = 6'd19,
        fn_mult  = 6'd24,
        fn_multu = 6'd25,
        fn_addu  = 6'd33,
        fn_subu  = 6'd35,
        fn_and   = 6'd36,
        fn_or    = 6'd37,
        fn_xor   = 6'd38,
        fn_nor   = 6'd39,
        fn_slt   = 6'd42,
        fn_sltu  = 6'd43
    } funct_t;

    // rt field of regimm opcode
    typedef enum logic [4:0] {
        ri_bltz   = 5'd0,
        ri_bgez   = 5'd1,
        ri_bltzal = 5'd16,
        ri_bgezal = 5'd17
    } regimm_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui, alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_ltz, br_gez
    } branch_t;

    typedef enum logic {
        st_execute = 1'b0,
        st_commit  = 1'b1
    } cpu_state_t;

    // reset vector
    localparam logic [31:0] BOOT_ADDR = 32'hBFC0_0000;

endpackage

`default_nettype wire
